// File: logic/pid_types_pkg.sv
package pid_types_pkg;

	//////////////////////////////
	// datapath widths
	//////////////////////////////

	// parallel adc word
	localparam int W_SAMPLE = 18;
	// coefficients and setpoint share the config word width
	localparam int W_COEF = 16;
	// pid terms and the integrator
	localparam int W_TERM = 40;
	// output multiplier
	localparam int W_MULT = 10;
	// output right shift count
	localparam int W_SHIFT = 5;
	// oversample exponent, block length is 2**os_exp
	localparam int W_OS = 4;

	//////////////////////////////
	// datapath types
	//////////////////////////////

	typedef logic signed [W_SAMPLE-1:0] sample_t;
	typedef logic signed [W_COEF-1:0] coef_t;
	typedef logic signed [W_TERM-1:0] term_t;
	// multiplier and shift are magnitudes only
	typedef logic [W_MULT-1:0] mult_t;
	typedef logic [W_SHIFT-1:0] shift_t;

endpackage

// File: logic/pid_cfg_pkg.sv
package pid_cfg_pkg;

	//////////////////////////////
	// register address map
	//////////////////////////////

	localparam int W_ADDR = 4;

	// one address per config register
	typedef enum logic [W_ADDR-1:0] {
		ADDR_OS       = 4'h0,
		ADDR_SETPOINT = 4'h1,
		ADDR_P_COEF   = 4'h2,
		ADDR_I_COEF   = 4'h3,
		ADDR_D_COEF   = 4'h4,
		ADDR_LOCK_EN  = 4'h5,
		ADDR_OUT_MIN  = 4'h6,
		ADDR_OUT_MAX  = 4'h7,
		ADDR_OUT_INIT = 4'h8,
		ADDR_MULT     = 4'h9,
		ADDR_SHIFT    = 4'ha
	} cfg_addr_t;

	//////////////////////////////
	// reset values
	//////////////////////////////

	// upper bound opens fully after reset, all other registers clear to zero
	localparam logic [pid_types_pkg::W_COEF-1:0] OUT_MAX_RESET = '1;

endpackage

// File: logic/pid_cfg_ifs.sv
// gain settings shared by both pid paths
interface gain_cfg_if import pid_types_pkg::*; ();
	coef_t setpoint;
	coef_t p_coef;
	coef_t i_coef;
	coef_t d_coef;
	// loop closed when high
	logic lock_en;

	modport source (
		output setpoint, p_coef, i_coef, d_coef, lock_en
	);
	modport sink (
		input setpoint, p_coef, i_coef, d_coef, lock_en
	);
endinterface

// output scaling and dac bounds
interface output_cfg_if import pid_types_pkg::*; #(
	parameter int W_OUT = 16
) ();
	// bounds and init are unsigned dac codes
	logic [W_OUT-1:0] out_min;
	logic [W_OUT-1:0] out_max;
	logic [W_OUT-1:0] out_init;
	mult_t mult;
	shift_t shift;

	modport source (
		output out_min, out_max, out_init, mult, shift
	);
	modport sink (
		input out_min, out_max, out_init, mult, shift
	);
endinterface

// File: logic/cfg_regs.sv
module cfg_regs import pid_types_pkg::*, pid_cfg_pkg::*; #(
	parameter int W_OUT = 16,
	parameter int OS_MAX = 8
) (
	input logic clk50_in,
	input logic sys_reset,
	input logic cfg_write,
	input cfg_addr_t cfg_addr,
	input coef_t cfg_data,
	output logic [W_OS-1:0] os_exp,
	gain_cfg_if.source gain,
	output_cfg_if.source outp
);

	//////////////////////////////
	// write decode helpers
	//////////////////////////////

	// requested exponent in the low bits of the data word
	logic [W_OS-1:0] os_req;
	// same request limited to the filter's largest block
	logic [W_OS-1:0] os_lim;

	assign os_req = cfg_data[W_OS-1:0];
	assign os_lim = (os_req > W_OS'(OS_MAX)) ? W_OS'(OS_MAX) : os_req;

	//////////////////////////////
	// register file
	//////////////////////////////

	// one register per address, value visible from the next edge
	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			os_exp <= '0;
			gain.setpoint <= '0;
			gain.p_coef <= '0;
			gain.i_coef <= '0;
			gain.d_coef <= '0;
			gain.lock_en <= 1'b0;
			outp.out_min <= '0;
			// full span until the host narrows it
			outp.out_max <= OUT_MAX_RESET[W_OUT-1:0];
			outp.out_init <= '0;
			outp.mult <= '0;
			outp.shift <= '0;
		end else if (cfg_write) begin
			case (cfg_addr)
				ADDR_OS: os_exp <= os_lim;
				// gains take the whole signed word
				ADDR_SETPOINT: gain.setpoint <= cfg_data;
				ADDR_P_COEF: gain.p_coef <= cfg_data;
				ADDR_I_COEF: gain.i_coef <= cfg_data;
				ADDR_D_COEF: gain.d_coef <= cfg_data;
				// lock enable is bit zero only
				ADDR_LOCK_EN: gain.lock_en <= cfg_data[0];
				// dac codes truncated to the output width
				ADDR_OUT_MIN: outp.out_min <= cfg_data[W_OUT-1:0];
				ADDR_OUT_MAX: outp.out_max <= cfg_data[W_OUT-1:0];
				ADDR_OUT_INIT: outp.out_init <= cfg_data[W_OUT-1:0];
				ADDR_MULT: outp.mult <= cfg_data[W_MULT-1:0];
				ADDR_SHIFT: outp.shift <= cfg_data[W_SHIFT-1:0];
				// unmapped addresses leave everything alone
				default: ;
			endcase
		end
	end

endmodule

// File: logic/oversample_filter.sv
module oversample_filter import pid_types_pkg::*; #(
	parameter int OS_MAX = 8
) (
	input logic clk50_in,
	input logic sys_reset,
	input sample_t sample,
	input logic sample_valid,
	input logic [W_OS-1:0] os_exp,
	output sample_t filt_sample,
	output logic filt_valid
);

	// room for 2**OS_MAX full scale samples
	localparam int W_ACC = W_SAMPLE + OS_MAX;
	localparam int W_CNT = OS_MAX + 1;

	logic signed [W_ACC-1:0] acc;
	logic signed [W_ACC-1:0] acc_next;
	logic signed [W_ACC-1:0] mean;
	logic [W_CNT-1:0] cnt;
	logic [W_CNT-1:0] blk_last;
	logic [W_OS-1:0] cur_exp;
	logic [W_OS-1:0] blk_exp;
	logic blk_done;

	// exponent is sampled at block start and held until the block ends
	assign blk_exp = (cnt == '0) ? os_exp : cur_exp;
	assign blk_last = (W_CNT'(1) << blk_exp) - W_CNT'(1);
	assign blk_done = sample_valid && (cnt == blk_last);
	// sign extended running sum
	assign acc_next = acc + W_ACC'(sample);
	// divide by block length
	assign mean = acc_next >>> blk_exp;

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			acc <= '0;
			cnt <= '0;
			cur_exp <= '0;
			filt_valid <= 1'b0;
		end else begin
			filt_valid <= blk_done;
			if (sample_valid) begin
				if (cnt == '0)
					cur_exp <= os_exp;
				// restart the block on its last sample
				if (blk_done) begin
					acc <= '0;
					cnt <= '0;
				end else begin
					acc <= acc_next;
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// mean word, only meaningful with filt_valid
	always_ff @(posedge clk50_in) begin
		if (blk_done)
			filt_sample <= mean[W_SAMPLE-1:0];
	end

endmodule

// File: logic/pd_path.sv
module pd_path import pid_types_pkg::*; (
	input logic clk50_in,
	input logic sys_reset,
	input sample_t filt_sample,
	input logic filt_valid,
	gain_cfg_if.sink gain,
	output term_t pd_term,
	output logic terms_valid
);

	// one guard bit for setpoint minus sample
	localparam int W_ERR = W_SAMPLE + 1;

	logic signed [W_ERR-1:0] err;
	logic signed [W_ERR-1:0] prev_err;
	logic signed [W_ERR:0] delta;
	term_t p_prod;
	term_t d_prod;

	//////////////////////////////
	// error and products
	//////////////////////////////

	assign err = gain.setpoint - filt_sample;
	// backward difference for the derivative
	assign delta = err - prev_err;
	// both products sign extended to term width before the multiply
	assign p_prod = gain.p_coef * err;
	assign d_prod = gain.d_coef * delta;

	//////////////////////////////
	// registers
	//////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			prev_err <= '0;
			pd_term <= '0;
			terms_valid <= 1'b0;
		end else begin
			// terms land in step with the integral path
			terms_valid <= filt_valid;
			if (filt_valid)
				pd_term <= p_prod + d_prod;
			// history held at zero while the loop is open
			if (!gain.lock_en)
				prev_err <= '0;
			else if (filt_valid)
				prev_err <= err;
		end
	end

endmodule

// File: logic/integral_path.sv
module integral_path import pid_types_pkg::*; (
	input logic clk50_in,
	input logic sys_reset,
	input sample_t filt_sample,
	input logic filt_valid,
	gain_cfg_if.sink gain,
	output term_t i_term
);

	localparam int W_ERR = W_SAMPLE + 1;
	// signed limits of the accumulator
	localparam term_t TERM_MAX = {1'b0, {(W_TERM-1){1'b1}}};
	localparam term_t TERM_MIN = {1'b1, {(W_TERM-1){1'b0}}};

	logic signed [W_ERR-1:0] err;
	term_t i_prod;
	// one extra bit to spot overflow
	logic signed [W_TERM:0] acc_sum;
	term_t acc_sat;

	// same error as the pd path, formed locally
	assign err = gain.setpoint - filt_sample;
	assign i_prod = gain.i_coef * err;
	assign acc_sum = i_term + i_prod;

	// top two bits differ on overflow, sign bit picks the rail
	always_comb begin
		if (acc_sum[W_TERM] != acc_sum[W_TERM-1])
			acc_sat = acc_sum[W_TERM] ? TERM_MIN : TERM_MAX;
		else
			acc_sat = acc_sum[W_TERM-1:0];
	end

	//////////////////////////////
	// integrator
	//////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			i_term <= '0;
		end else if (!gain.lock_en) begin
			// open loop keeps the integrator empty
			i_term <= '0;
		end else if (filt_valid) begin
			i_term <= acc_sat;
		end
	end

endmodule

// File: logic/output_stage.sv
module output_stage import pid_types_pkg::*; #(
	parameter int W_OUT = 16
) (
	input logic clk50_in,
	input logic sys_reset,
	input term_t pd_term,
	input term_t i_term,
	input logic terms_valid,
	input logic inject,
	input logic lock_en,
	output_cfg_if.sink outp,
	output logic [W_OUT-1:0] out_word,
	output logic out_valid
);

	localparam int W_SUM = W_TERM + 1;
	// sum times a zero extended multiplier
	localparam int W_PROD = W_SUM + W_MULT + 1;
	// plus the init offset
	localparam int W_FIN = W_PROD + 1;

	term_t held_pd;
	term_t held_i;
	term_t use_pd;
	term_t use_i;
	logic signed [W_SUM-1:0] term_sum;
	logic signed [W_MULT:0] mult_s;
	logic signed [W_PROD-1:0] scaled;
	logic signed [W_PROD-1:0] s1_val;
	logic s1_fire;
	logic s1_valid;
	logic signed [W_FIN-1:0] pre;
	logic signed [W_FIN-1:0] lo;
	logic signed [W_FIN-1:0] hi;
	logic signed [W_FIN-1:0] clamped;

	//////////////////////////////
	// stage one, sum and scale
	//////////////////////////////

	// fresh terms win over held ones when inject coincides
	assign use_pd = terms_valid ? pd_term : held_pd;
	assign use_i = terms_valid ? i_term : held_i;
	assign term_sum = use_pd + use_i;
	assign mult_s = {1'b0, outp.mult};
	assign scaled = (term_sum * mult_s) >>> outp.shift;
	assign s1_fire = terms_valid | inject;

	always_ff @(posedge clk50_in) begin
		if (sys_reset) begin
			held_pd <= '0;
			held_i <= '0;
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= s1_fire;
			// keep the last terms for later injects
			if (terms_valid) begin
				held_pd <= pd_term;
				held_i <= i_term;
			end
		end
	end

	// open loop drops the pid contribution so only init remains
	always_ff @(posedge clk50_in) begin
		if (s1_fire)
			s1_val <= lock_en ? scaled : '0;
	end

	//////////////////////////////
	// stage two, offset and clamp
	//////////////////////////////

	// unsigned codes get a zero sign bit
	assign pre = s1_val + $signed({1'b0, outp.out_init});
	assign lo = $signed({1'b0, outp.out_min});
	assign hi = $signed({1'b0, outp.out_max});

	always_comb begin
		if (pre > hi)
			clamped = hi;
		else if (pre < lo)
			clamped = lo;
		else
			clamped = pre;
	end

	always_ff @(posedge clk50_in) begin
		if (sys_reset)
			out_valid <= 1'b0;
		else
			out_valid <= s1_valid;
	end

	// dac code, sign bit discarded after the clamp
	always_ff @(posedge clk50_in) begin
		if (s1_valid)
			out_word <= clamped[W_OUT-1:0];
	end

endmodule

// File: logic/pid_channel.sv
module pid_channel import pid_types_pkg::*, pid_cfg_pkg::*; #(
	parameter int W_OUT = 16,
	parameter int OS_MAX = 8
) (
	input logic clk50_in,
	input logic sys_reset,
	input sample_t sample,
	input logic sample_valid,
	input logic cfg_write,
	input cfg_addr_t cfg_addr,
	input coef_t cfg_data,
	input logic inject,
	output sample_t filt_sample,
	output logic filt_valid,
	output logic [W_OUT-1:0] out_word,
	output logic out_valid
);

	//////////////////////////////
	// internal wiring
	//////////////////////////////

	logic [W_OS-1:0] os_exp;
	term_t pd_term;
	term_t i_term;
	logic terms_valid;

	// config buses from the register file
	gain_cfg_if gain ();
	output_cfg_if #(.W_OUT(W_OUT)) outp ();

	//////////////////////////////
	// instances
	//////////////////////////////

	// host side register writes
	cfg_regs #(.W_OUT(W_OUT), .OS_MAX(OS_MAX)) u_cfg_regs (
		.clk50_in(clk50_in), .sys_reset(sys_reset),
		.cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.os_exp(os_exp), .gain(gain.source), .outp(outp.source)
	);

	// block mean of the raw samples, also exposed for monitoring
	oversample_filter #(.OS_MAX(OS_MAX)) u_filter (
		.clk50_in(clk50_in), .sys_reset(sys_reset),
		.sample(sample), .sample_valid(sample_valid), .os_exp(os_exp),
		.filt_sample(filt_sample), .filt_valid(filt_valid)
	);

	// p and d terms, source of terms_valid
	pd_path u_pd_path (
		.clk50_in(clk50_in), .sys_reset(sys_reset),
		.filt_sample(filt_sample), .filt_valid(filt_valid), .gain(gain.sink),
		.pd_term(pd_term), .terms_valid(terms_valid)
	);

	integral_path u_integral_path (
		.clk50_in(clk50_in), .sys_reset(sys_reset),
		.filt_sample(filt_sample), .filt_valid(filt_valid), .gain(gain.sink),
		.i_term(i_term)
	);

	// scale, offset and clamp into the dac word
	output_stage #(.W_OUT(W_OUT)) u_output_stage (
		.clk50_in(clk50_in), .sys_reset(sys_reset),
		.pd_term(pd_term), .i_term(i_term), .terms_valid(terms_valid),
		.inject(inject), .lock_en(gain.lock_en), .outp(outp.sink),
		.out_word(out_word), .out_valid(out_valid)
	);

endmodule

// File: verification/pid_checker.sv
module pid_checker import pid_types_pkg::*, pid_cfg_pkg::*; (
	input logic clk50_in,
	input logic sys_reset,
	input sample_t sample,
	input logic sample_valid,
	input logic cfg_write,
	input cfg_addr_t cfg_addr,
	input coef_t cfg_data,
	input logic inject,
	input sample_t filt_sample,
	input logic filt_valid,
	input logic [15:0] out_word,
	input logic out_valid,
	input int test_id
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int OS_LIMIT = 8;
	// signed rails of the 40 bit integrator
	localparam longint TERM_HI = (64'sd1 <<< 39) - 1;
	localparam longint TERM_LO = -(64'sd1 <<< 39);

	int checks, value_errors, other_errors;
	sample_t filt_q[$];
	logic [15:0] out_q[$];
	// register mirror
	int m_os;
	bit m_lock;
	longint m_sp, m_p, m_i, m_d, m_min, m_max, m_init, m_mult, m_shift;
	// model state, the _d flags are strobes waiting one edge
	longint f_acc, f_val, prev_err, pd_reg, i_reg, held_pd, held_i;
	int f_cnt, f_exp;
	bit fv_d, tv_d;

	function automatic string test_name(input int id);
		case (id)
			1: return "unlocked_init";
			2: return "oversample";
			3: return "locked_pid";
			4: return "clamp";
			5: return "inject";
			6: return "relock";
			default: return "reset";
		endcase
	endfunction

	// work still expected from the dut
	function automatic int outstanding();
		return filt_q.size() + out_q.size() + int'(fv_d) + int'(tv_d);
	endfunction

	always @(posedge clk50_in) begin
		longint err, sum, pre;
		sample_t exp_f;
		logic [15:0] exp_o;
		if (sys_reset) begin
			filt_q.delete();
			out_q.delete();
			{m_os, m_lock, m_sp, m_p, m_i, m_d, m_min, m_init, m_mult, m_shift} = '0;
			m_max = 64'hffff;
			{f_acc, f_val, prev_err, pd_reg, i_reg, held_pd, held_i} = '0;
			{f_cnt, f_exp, fv_d, tv_d} = '0;
		end else begin
			//////////////////////////////
			// compare dut strobes
			if (filt_valid) begin
				if (filt_q.size() == 0) begin
					$display("filt_valid fired in %s with no completed block", test_name(test_id));
					other_errors++;
				end else begin
					exp_f = filt_q.pop_front();
					checks++;
					if (filt_sample !== exp_f) begin
						$display("Error %s filt_sample expected %0d actual %0d",
							test_name(test_id), exp_f, filt_sample);
						value_errors++;
					end
				end
			end
			if (out_valid) begin
				if (out_q.size() == 0) begin
					$display("out_valid fired in %s with no update pending", test_name(test_id));
					other_errors++;
				end else begin
					exp_o = out_q.pop_front();
					checks++;
					if (out_word !== exp_o) begin
						$display("Error %s out_word expected %0d actual %0d",
							test_name(test_id), exp_o, out_word);
						value_errors++;
					end
				end
			end
			//////////////////////////////
			// output update, new terms or inject
			if (tv_d || inject) begin
				if (tv_d) begin
					held_pd = pd_reg;
					held_i = i_reg;
				end
				sum = held_pd + held_i;
				pre = (m_lock ? ((sum * m_mult) >>> m_shift) : 0) + m_init;
				if (pre > m_max)
					pre = m_max;
				else if (pre < m_min)
					pre = m_min;
				out_q.push_back(pre[15:0]);
			end
			tv_d = 1'b0;
			// pid law on the filtered sample
			err = m_sp - f_val;
			if (fv_d) begin
				pd_reg = m_p * err + m_d * (err - prev_err);
				tv_d = 1'b1;
			end
			if (!m_lock) begin
				prev_err = 0;
				i_reg = 0;
			end else if (fv_d) begin
				prev_err = err;
				sum = i_reg + m_i * err;
				i_reg = (sum > TERM_HI) ? TERM_HI : (sum < TERM_LO) ? TERM_LO : sum;
			end
			fv_d = 1'b0;
			// block mean, exponent latched on the first sample
			if (sample_valid) begin
				if (f_cnt == 0)
					f_exp = m_os;
				f_acc += sample;
				f_cnt++;
				if (f_cnt == (1 << f_exp)) begin
					exp_f = sample_t'(f_acc >>> f_exp);
					filt_q.push_back(exp_f);
					f_val = exp_f;
					fv_d = 1'b1;
					f_acc = 0;
					f_cnt = 0;
				end
			end
			// register writes count from the next edge
			if (cfg_write) begin
				case (cfg_addr)
					ADDR_OS: m_os = (cfg_data[3:0] > OS_LIMIT) ? OS_LIMIT : cfg_data[3:0];
					ADDR_SETPOINT: m_sp = cfg_data;
					ADDR_P_COEF: m_p = cfg_data;
					ADDR_I_COEF: m_i = cfg_data;
					ADDR_D_COEF: m_d = cfg_data;
					ADDR_LOCK_EN: m_lock = cfg_data[0];
					ADDR_OUT_MIN: m_min = longint'(cfg_data[15:0]);
					ADDR_OUT_MAX: m_max = longint'(cfg_data[15:0]);
					ADDR_OUT_INIT: m_init = longint'(cfg_data[15:0]);
					ADDR_MULT: m_mult = longint'(cfg_data[9:0]);
					ADDR_SHIFT: m_shift = longint'(cfg_data[4:0]);
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verification/tb_pid_channel.sv
module tb_pid_channel import pid_types_pkg::*, pid_cfg_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam logic [31:0] SEED = 32'h1393;
	// rough cycle budget of each test
	localparam int TOTAL_CYCLES = 300 + 3200 + 1500 + 300 + 200 + 400;

	logic clk50_in, sys_reset, sample_valid, cfg_write, inject, filt_valid, out_valid;
	sample_t sample, filt_sample;
	cfg_addr_t cfg_addr;
	coef_t cfg_data;
	logic [15:0] out_word;
	logic [31:0] lfsr;
	int test_id;
	int v;

	pid_channel #(.W_OUT(16), .OS_MAX(8)) dut (.*);

	pid_checker monitor (.*);

	initial begin
		clk50_in = 1'b0;
		forever #(CLK_PERIOD / 2) clk50_in = ~clk50_in;
	end

	// watchdog
	initial begin
		#(TOTAL_CYCLES * 2 * CLK_PERIOD);
		$display("timeout: the tests did not finish within the cycle budget");
		$display("*** FAILED ***");
		$finish;
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic write_reg(input cfg_addr_t a, input logic [15:0] d);
		@(posedge clk50_in);
		cfg_write <= 1'b1;
		cfg_addr <= a;
		cfg_data <= d;
		@(posedge clk50_in);
		cfg_write <= 1'b0;
	endtask

	// back to back samples where negative ones drive the integrator to its rail
	task automatic run_block(input int n, input bit negative);
		for (int i = 0; i < n; i++) begin
			@(posedge clk50_in);
			sample <= negative ? {1'b1, 17'(rand_bits(17))} : sample_t'(rand_bits(18));
			sample_valid <= 1'b1;
		end
		@(posedge clk50_in);
		sample_valid <= 1'b0;
	endtask

	task automatic pulse_inject();
		@(posedge clk50_in);
		inject <= 1'b1;
		@(posedge clk50_in);
		inject <= 1'b0;
	endtask

	task automatic wait_idle();
		@(posedge clk50_in);
		while (monitor.outstanding() != 0)
			@(posedge clk50_in);
	endtask

	initial begin
		lfsr = SEED;
		sys_reset = 1'b1;
		sample_valid = 1'b0;
		cfg_write = 1'b0;
		inject = 1'b0;
		test_id = 0;
		sample = '0;
		cfg_addr = ADDR_OS;
		cfg_data = '0;
		repeat (3) @(posedge clk50_in);
		sys_reset <= 1'b0;
		// open loop gives only the clamped init value
		repeat (10) @(posedge clk50_in);
		test_id <= 1;
		write_reg(ADDR_OUT_INIT, rand_bits(16));
		write_reg(ADDR_OUT_MIN, rand_bits(15));
		write_reg(ADDR_OS, 16'd2);
		repeat (3) run_block(4, 1'b0);
		pulse_inject();
		wait_idle();
		test_id <= 2;
		for (int k = 0; k < 10; k++) begin
			v = rand_bits(4);
			write_reg(ADDR_OS, 16'(v));
			run_block(1 << ((v > 8) ? 8 : v), 1'b0);
			wait_idle();
		end
		// closed loop with random gains
		test_id <= 3;
		write_reg(ADDR_OUT_MIN, 16'd0);
		write_reg(ADDR_OUT_MAX, 16'hffff);
		write_reg(ADDR_SETPOINT, rand_bits(16));
		write_reg(ADDR_P_COEF, 16'(signed'(8'(rand_bits(8)))));
		write_reg(ADDR_I_COEF, 16'(signed'(6'(rand_bits(6)))));
		write_reg(ADDR_D_COEF, 16'(signed'(8'(rand_bits(8)))));
		write_reg(ADDR_MULT, rand_bits(10));
		write_reg(ADDR_SHIFT, 16'd20 + rand_bits(3));
		write_reg(ADDR_OS, rand_bits(2));
		write_reg(ADDR_LOCK_EN, 16'd1);
		repeat (20) run_block(8, 1'b0);
		wait_idle();
		// large gain on a far setpoint reaches the integrator rail
		write_reg(ADDR_OS, 16'd0);
		// unit scale keeps the rail inside the dac span
		write_reg(ADDR_MULT, 16'd1);
		write_reg(ADDR_SHIFT, 16'd24);
		write_reg(ADDR_OUT_INIT, 16'd0);
		write_reg(ADDR_I_COEF, 16'h7fff);
		write_reg(ADDR_SETPOINT, 16'h7fff);
		repeat (250) run_block(1, 1'b1);
		wait_idle();
		test_id <= 4;
		write_reg(ADDR_I_COEF, 16'd3);
		v = rand_bits(16);
		write_reg(ADDR_OUT_MIN, 16'(v));
		write_reg(ADDR_OUT_MAX, 16'(v + rand_bits(6)));
		repeat (30) run_block(2, 1'b0);
		wait_idle();
		// inject alone and then in the cycle of terms_valid
		test_id <= 5;
		// full dac span so the held terms reach the output
		write_reg(ADDR_OUT_MIN, 16'd0);
		write_reg(ADDR_OUT_MAX, 16'hffff);
		pulse_inject();
		wait_idle();
		run_block(1, 1'b0);
		pulse_inject();
		wait_idle();
		test_id <= 6;
		write_reg(ADDR_LOCK_EN, 16'd0);
		// finer scale so the restart of both paths shows on the output
		write_reg(ADDR_SHIFT, 16'd10);
		run_block(4, 1'b0);
		wait_idle();
		write_reg(ADDR_LOCK_EN, 16'd1);
		repeat (20) run_block(2, 1'b0);
		wait_idle();
		repeat (5) @(posedge clk50_in);
		$display("checks %0d, value errors %0d, other errors %0d",
			monitor.checks, monitor.value_errors, monitor.other_errors);
		if (monitor.value_errors == 0 && monitor.other_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
logic/pid_types_pkg.sv
logic/pid_cfg_pkg.sv
logic/pid_cfg_ifs.sv
logic/cfg_regs.sv
logic/oversample_filter.sv
logic/pd_path.sv
logic/integral_path.sv
logic/output_stage.sv
logic/pid_channel.sv
verification/pid_checker.sv
verification/tb_pid_channel.sv

// File: Makefile
# Verilator simulation of the PID channel testbench

VERILATOR ?= verilator
TOP       ?= tb_pid_channel
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

PASS_TEXT = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
